// ==== flist.f ====
+incdir+verilog
verilog/simd_alu_pkg.sv
verilog/simd_compare.sv
verilog/simd_addsub.sv
verilog/simd_bitwise.sv
verilog/simd_alu.sv
verif/simd_alu_asserts.sv
verif/simd_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the SIMD ALU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module simd_alu_tb \
  -o simd_alu_sim -f flist.f || { echo "Build failed"; exit 1; }
sim_out=$(./obj_dir/simd_alu_sim +verilator+error+limit+1000)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== verif/simd_alu_asserts.sv ====
// SIMD ALU timing checks
// Bound to the top level to check latency, reset and zeroed outputs

`timescale 1ns/10ps

`include "simd_alu_macros.svh"

module simd_alu_asserts import simd_alu_pkg::*; (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    valid_i,
  input alu_op_e                 op_i,
  input vew_e                    vew_i,
  input logic                    valid_o,
  input logic [`SIMD_DATA_W-1:0] result_o,
  input logic [`SIMD_STRB_W-1:0] vxsat_o
);

  logic                    sat_op;
  logic                    cmp_op;
  logic [`SIMD_DATA_W-1:0] bit0_mask;
  int                      fail_count = 0;

  assign sat_op = op_i inside {OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB};
  assign cmp_op = op_i inside {OP_MSEQ, OP_MSNE, OP_MSLT, OP_MSLTU,
                               OP_MSLE, OP_MSLEU, OP_MSGT, OP_MSGTU};

  // Bit 0 of every element
  always_comb begin
    case (vew_i)
      EW8:     bit0_mask = 64'h0101_0101_0101_0101;
      EW16:    bit0_mask = 64'h0001_0001_0001_0001;
      EW32:    bit0_mask = 64'h0000_0001_0000_0001;
      default: bit0_mask = 64'h0000_0000_0000_0001;
    endcase
  end

  a_reset_clears: assert property (@(posedge clk_i)
    $past(reset_i) |-> !valid_o && result_o == '0 && vxsat_o == '0)
    else begin
      $error("outputs not cleared by reset");
      fail_count++;
    end

  a_valid_delay: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o == $past(valid_i))
    else begin
      $error("valid_o is not valid_i delayed by one cycle");
      fail_count++;
    end

  a_idle_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    !valid_o |-> result_o == '0 && vxsat_o == '0)
    else begin
      $error("result or vxsat nonzero while valid_o is low");
      fail_count++;
    end

  a_no_sat: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !$past(sat_op) |-> vxsat_o == '0)
    else begin
      $error("vxsat set by a non-saturating operation");
      fail_count++;
    end

  a_cmp_bit0: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && $past(cmp_op) |-> (result_o & ~$past(bit0_mask)) == '0)
    else begin
      $error("compare result has bits set above bit 0 of an element");
      fail_count++;
    end

endmodule

bind simd_alu simd_alu_asserts u_asserts (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .valid_i  (valid_i),
  .op_i     (op_i),
  .vew_i    (vew_i),
  .valid_o  (valid_o),
  .result_o (result_o),
  .vxsat_o  (vxsat_o)
);

// ==== verif/simd_alu_tb.sv ====
// SIMD ALU testbench
// LCG operands and directed corners against a lane model with one-cycle latency checks

`timescale 1ns/10ps

`include "simd_alu_macros.svh"

module simd_alu_tb import simd_alu_pkg::*; ();

  // About 420 operations plus reset and idle gaps
  localparam int CYCLE_LIMIT = 600;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic                    valid_i;
  alu_op_e                 op_i;
  vew_e                    vew_i;
  logic [`SIMD_DATA_W-1:0] operand_a_i;
  logic [`SIMD_DATA_W-1:0] operand_b_i;
  logic                    valid_o;
  logic [`SIMD_DATA_W-1:0] result_o;
  logic [`SIMD_STRB_W-1:0] vxsat_o;

  logic [31:0] lcg_state = 32'd47827;
  int          cycle_count = 0;
  int          value_errors = 0;
  int          timing_errors = 0;
  int          results_checked = 0;

  // Expected responses for at most one op in flight
  string                   name_q[$];
  logic [`SIMD_DATA_W-1:0] res_q[$];
  logic [`SIMD_STRB_W-1:0] sat_q[$];
  logic                    last_valid = 1'b0;
  string                   last_name = "reset";

  simd_alu dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_random();
    lo = next_random();
    return {hi, lo};
  endfunction

  function automatic logic [63:0] lane_mask(input int w);
    return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
  endfunction

  // Same lane value in every lane of the word
  function automatic logic [63:0] replicate(input logic [63:0] lane, input vew_e ew);
    int          w;
    logic [63:0] r;
    w = 8 << int'(ew);
    r = '0;
    for (int l = 0; l < 64 / w; l++)
      r = r | ((lane & lane_mask(w)) << (l * w));
    return r;
  endfunction

  function automatic logic signed [65:0] widen(input logic [63:0] x, input int w,
                                               input logic sgn);
    if (sgn && x[w-1])
      return {2'b11, x | ~lane_mask(w)};
    return {2'b00, x};
  endfunction

  ////////////////////////////////////////
  // Lane model
  ////////////////////////////////////////

  function automatic void compute_expected(input alu_op_e op, input vew_e ew,
                                           input logic [63:0] a, input logic [63:0] b,
                                           output logic [63:0] res, output logic [7:0] sat);
    int                 w;
    int                 amt;
    logic [63:0]        m;
    logic [63:0]        la;
    logic [63:0]        lb;
    logic [63:0]        r;
    logic [7:0]         bm;
    logic signed [65:0] va;
    logic signed [65:0] vb;
    logic signed [65:0] s;
    logic signed [65:0] smax;
    logic signed [65:0] smin;
    logic               sgn;
    logic               lsat;
    w    = 8 << int'(ew);
    m    = lane_mask(w);
    bm   = (w == 64) ? 8'hFF : 8'((1 << (w / 8)) - 1);
    sgn  = op inside {OP_SADD, OP_SSUB, OP_SRA, OP_MIN, OP_MAX, OP_MSLT, OP_MSLE, OP_MSGT};
    smax = sgn ? $signed({2'b00, m >> 1}) : $signed({2'b00, m});
    smin = sgn ? -smax - 66'sd1 : 66'sd0;
    res  = '0;
    sat  = '0;
    for (int l = 0; l < 64 / w; l++) begin
      la   = (a >> (l * w)) & m;
      lb   = (b >> (l * w)) & m;
      va   = widen(la, w, sgn);
      vb   = widen(lb, w, sgn);
      amt  = int'(la[5:0]) & (w - 1);
      lsat = 1'b0;
      case (op)
        OP_AND:  r = la & lb;
        OP_OR:   r = la | lb;
        OP_XOR:  r = la ^ lb;
        OP_ADD:  r = lb + la;
        OP_SUB:  r = lb - la;
        OP_RSUB: r = la - lb;
        OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB: begin
          s = (op inside {OP_SADDU, OP_SADD}) ? vb + va : vb - va;
          if (s > smax) begin
            r    = smax[63:0];
            lsat = 1'b1;
          end else if (s < smin) begin
            r    = smin[63:0];
            lsat = 1'b1;
          end else begin
            r = s[63:0];
          end
        end
        OP_SLL:             r = lb << amt;
        OP_SRL:             r = lb >> amt;
        OP_SRA:             r = 64'(vb >>> amt);
        OP_MIN, OP_MINU:    r = (vb < va) ? lb : la;
        OP_MAX, OP_MAXU:    r = (vb > va) ? lb : la;
        OP_MSEQ:            r = 64'(vb == va);
        OP_MSNE:            r = 64'(vb != va);
        OP_MSLT, OP_MSLTU:  r = 64'(vb < va);
        OP_MSLE, OP_MSLEU:  r = 64'(vb <= va);
        OP_MSGT, OP_MSGTU:  r = 64'(vb > va);
        default:            r = '0;
      endcase
      res = res | ((r & m) << (l * w));
      if (lsat)
        sat = sat | (bm << (l * w / 8));
    end
  endfunction

  ////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////

  // Outputs settle after the rising edge, so look at them on the falling edge
  task automatic check_outputs();
    string                   name;
    logic [`SIMD_DATA_W-1:0] exp_res;
    logic [`SIMD_STRB_W-1:0] exp_sat;
    if (valid_o !== last_valid) begin
      $display("CHECK FAILED %s: valid_o expected %0b, actual %0b",
               last_name, last_valid, valid_o);
      timing_errors++;
    end
    if (valid_o === 1'b1) begin
      if (name_q.size() == 0) begin
        $display("valid_o went high with no operation waiting for a result");
        timing_errors++;
      end else begin
        name    = name_q.pop_front();
        exp_res = res_q.pop_front();
        exp_sat = sat_q.pop_front();
        results_checked++;
        if (result_o !== exp_res) begin
          $display("CHECK FAILED %s: result expected %h, actual %h", name, exp_res, result_o);
          value_errors++;
        end
        if (vxsat_o !== exp_sat) begin
          $display("CHECK FAILED %s: vxsat expected %h, actual %h", name, exp_sat, vxsat_o);
          value_errors++;
        end
      end
    end else begin
      // Drop results that never showed up
      name_q.delete();
      res_q.delete();
      sat_q.delete();
      if (result_o !== '0 || vxsat_o !== '0) begin
        $display("CHECK FAILED idle: result/vxsat expected 0/0, actual %h/%h",
                 result_o, vxsat_o);
        value_errors++;
      end
    end
  endtask

  task automatic issue_op(input string name, input alu_op_e op, input vew_e ew,
                          input logic [63:0] a, input logic [63:0] b);
    logic [`SIMD_DATA_W-1:0] exp_res;
    logic [`SIMD_STRB_W-1:0] exp_sat;
    @(negedge clk_i);
    check_outputs();
    valid_i     = 1'b1;
    op_i        = op;
    vew_i       = ew;
    operand_a_i = a;
    operand_b_i = b;
    compute_expected(op, ew, a, b, exp_res, exp_sat);
    last_valid = 1'b1;
    last_name  = $sformatf("%s %s %s", name, op.name(), ew.name());
    name_q.push_back(last_name);
    res_q.push_back(exp_res);
    sat_q.push_back(exp_sat);
  endtask

  // Garbage on the operands must not leak out
  task automatic idle_cycle();
    @(negedge clk_i);
    check_outputs();
    valid_i     = 1'b0;
    operand_a_i = random_word();
    operand_b_i = random_word();
    last_valid  = 1'b0;
    last_name   = "idle";
  endtask

  ////////////////////////////////////////
  // Test groups
  ////////////////////////////////////////

  task automatic arith_sweep();
    vew_e        ew;
    alu_op_e     op;
    logic [63:0] smax;
    logic [63:0] smin;
    for (int e = 0; e < 4; e++) begin
      ew   = vew_e'(e);
      smax = replicate(lane_mask(8 << e) >> 1, ew);
      smin = replicate(~(lane_mask(8 << e) >> 1), ew);
      for (int k = int'(OP_ADD); k <= int'(OP_SSUB); k++) begin
        op = alu_op_e'(k);
        issue_op("arith random", op, ew, random_word(), random_word());
        issue_op("arith all ones", op, ew, '1, '1);
        issue_op("arith max plus max", op, ew, smax, smax);
        issue_op("arith min minus max", op, ew, smax, smin);
        issue_op("arith zero minus ones", op, ew, '1, '0);
      end
    end
  endtask

  task automatic bitwise_shift_sweep();
    vew_e    ew;
    alu_op_e op;
    for (int e = 0; e < 4; e++) begin
      ew = vew_e'(e);
      for (int k = int'(OP_AND); k <= int'(OP_SRA); k++) begin
        op = alu_op_e'(k);
        if (op inside {OP_ADD, OP_SUB, OP_RSUB, OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB})
          continue;
        repeat (3) issue_op("bitwise random", op, ew, random_word(), random_word());
        if (op inside {OP_SLL, OP_SRL, OP_SRA})
          issue_op("shift max amount", op, ew, replicate(64'((8 << e) - 1), ew),
                   random_word());
      end
    end
  endtask

  task automatic minmax_compare_sweep();
    vew_e        ew;
    alu_op_e     op;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] smax;
    logic [63:0] smin;
    for (int e = 0; e < 4; e++) begin
      ew   = vew_e'(e);
      smax = replicate(lane_mask(8 << e) >> 1, ew);
      smin = replicate(~(lane_mask(8 << e) >> 1), ew);
      for (int k = int'(OP_MIN); k <= int'(OP_MSGTU); k++) begin
        op = alu_op_e'(k);
        a  = random_word();
        b  = random_word();
        issue_op("cmp random", op, ew, a, b);
        issue_op("cmp equal", op, ew, a, a);
        issue_op("cmp sign flip", op, ew, a, a ^ smin);
        issue_op("cmp min vs max", op, ew, smax, smin);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    op_i        = OP_AND;
    vew_i       = EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_outputs();
    reset_i = 1'b0;
    repeat (3) idle_cycle();
    arith_sweep();
    idle_cycle();
    bitwise_shift_sweep();
    idle_cycle();
    minmax_compare_sweep();
    repeat (2) idle_cycle();
    $display("Checked %0d results: %0d value, %0d timing, %0d assertion errors",
             results_checked, value_errors, timing_errors, dut.u_asserts.fail_count);
    if (value_errors == 0 && timing_errors == 0 && dut.u_asserts.fail_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verilog/simd_addsub.sv ====
// SIMD add and subtract unit
// Wrapping and saturating lane arithmetic with per-byte saturation flags

`timescale 1ns/10ps

`include "simd_alu_macros.svh"

module simd_addsub import simd_alu_pkg::*; (
  input  alu_op_e                 op_i,
  input  vew_e                    vew_i,
  input  logic [`SIMD_DATA_W-1:0] operand_a_i,
  input  logic [`SIMD_DATA_W-1:0] operand_b_i,
  output logic [`SIMD_DATA_W-1:0] result_o,
  output logic [`SIMD_STRB_W-1:0] vxsat_o
);

  logic is_own;
  logic is_sub;
  logic is_rsub;
  logic sat_u;
  logic sat_s;

  // One candidate result per element width
  logic [`SIMD_NUM_EW-1:0][`SIMD_DATA_W-1:0] res_ew;
  logic [`SIMD_NUM_EW-1:0][`SIMD_STRB_W-1:0] sat_ew;

  ////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////

  assign is_own  = op_i inside {OP_ADD, OP_SUB, OP_RSUB,
                                OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB};
  assign is_sub  = op_i inside {OP_SUB, OP_RSUB, OP_SSUBU, OP_SSUB};
  assign is_rsub = op_i == OP_RSUB;
  assign sat_u   = op_i inside {OP_SADDU, OP_SSUBU};
  assign sat_s   = op_i inside {OP_SADD, OP_SSUB};

  ////////////////////////////////////////
  // Lane arithmetic
  ////////////////////////////////////////

  for (genvar g = 0; g < `SIMD_NUM_EW; g++) begin : g_ew
    localparam int unsigned W     = `SIMD_EW8_W << g;
    localparam int unsigned LANES = `SIMD_DATA_W / W;
    localparam int unsigned BYTES = W / 8;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [W-1:0] x;
      logic [W-1:0] y;
      logic [W:0]   ext;
      logic [W-1:0] clamp_s;
      logic         ovf_u;
      logic         ovf_s;
      logic         lane_sat_u;
      logic         lane_sat_s;

      // b op a, except reverse subtract which is a - b
      assign x = is_rsub ? operand_a_i[l*W +: W] : operand_b_i[l*W +: W];
      assign y = is_rsub ? operand_b_i[l*W +: W] : operand_a_i[l*W +: W];

      // Extra top bit holds carry or borrow
      assign ext = is_sub ? {1'b0, x} - {1'b0, y} : {1'b0, x} + {1'b0, y};

      assign ovf_u = ext[W];

      // Signs agree for add or differ for sub, and result sign leaves x
      assign ovf_s = ((x[W-1] ^ y[W-1]) == is_sub) && (ext[W-1] != x[W-1]);

      // Overflow always goes toward the sign of x
      assign clamp_s = {x[W-1], {(W-1){~x[W-1]}}};

      assign lane_sat_u = sat_u & ovf_u;
      assign lane_sat_s = sat_s & ovf_s;

      // Unsigned clamp: all ones on add, zero on sub
      assign res_ew[g][l*W +: W] = lane_sat_u ? {W{~is_sub}} :
                                   lane_sat_s ? clamp_s : ext[W-1:0];

      assign sat_ew[g][l*BYTES +: BYTES] = {BYTES{lane_sat_u | lane_sat_s}};
    end
  end

  ////////////////////////////////////////
  // Width select
  ////////////////////////////////////////

  assign result_o = is_own ? res_ew[vew_i] : '0;
  assign vxsat_o  = is_own ? sat_ew[vew_i] : '0;

endmodule

// ==== verilog/simd_alu.sv ====
// SIMD integer ALU top
// Runs the three lane units in parallel and registers result, flags and valid

`timescale 1ns/10ps

`include "simd_alu_macros.svh"

module simd_alu import simd_alu_pkg::*; (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid_i,
  input  alu_op_e                 op_i,
  input  vew_e                    vew_i,
  input  logic [`SIMD_DATA_W-1:0] operand_a_i,
  input  logic [`SIMD_DATA_W-1:0] operand_b_i,
  output logic                    valid_o,
  output logic [`SIMD_DATA_W-1:0] result_o,
  output logic [`SIMD_STRB_W-1:0] vxsat_o
);

  logic [`SIMD_DATA_W-1:0] cmp_res;
  logic [`SIMD_DATA_W-1:0] arith_res;
  logic [`SIMD_DATA_W-1:0] logic_res;
  logic [`SIMD_DATA_W-1:0] alu_res;
  logic [`SIMD_STRB_W-1:0] arith_sat;

  ////////////////////////////////////////
  // Lane units
  ////////////////////////////////////////

  simd_compare u_compare (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (cmp_res)
  );

  simd_addsub u_addsub (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (arith_res),
    .vxsat_o     (arith_sat)
  );

  simd_bitwise u_bitwise (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (logic_res)
  );

  // Units not owning the op drive zero
  assign alu_res = cmp_res | arith_res | logic_res;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      valid_o  <= valid_i;
      result_o <= valid_i ? alu_res : '0;
      vxsat_o  <= valid_i ? arith_sat : '0;
    end
  end

endmodule

// ==== verilog/simd_alu_macros.svh ====
// SIMD ALU constants
// Word, byte and element widths shared by the datapath and the package

`ifndef SIMD_ALU_MACROS_SVH
`define SIMD_ALU_MACROS_SVH

// Operand and result word
`define SIMD_DATA_W 64

// One saturation flag per byte of the word
`define SIMD_STRB_W 8

// Supported element widths
`define SIMD_EW8_W  8
`define SIMD_EW16_W 16
`define SIMD_EW32_W 32
`define SIMD_EW64_W 64

// Number of element widths, smallest first
`define SIMD_NUM_EW 4

`endif

// ==== verilog/simd_alu_pkg.sv ====
// SIMD ALU package
// Operation and element-width encodings, and the lane view of one word

`include "simd_alu_macros.svh"

package simd_alu_pkg;

  // Kept vector integer operations
  typedef enum logic [4:0] {
    OP_AND, OP_OR, OP_XOR,
    OP_ADD, OP_SUB, OP_RSUB,
    OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB,
    OP_SLL, OP_SRL, OP_SRA,
    OP_MIN, OP_MINU, OP_MAX, OP_MAXU,
    OP_MSEQ, OP_MSNE,
    OP_MSLT, OP_MSLTU,
    OP_MSLE, OP_MSLEU,
    OP_MSGT, OP_MSGTU
  } alu_op_e;

  // Element width, in the order of the lane widths
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Same 64-bit word seen as 1, 2, 4 or 8 lanes
  typedef union packed {
    logic [`SIMD_DATA_W/`SIMD_EW64_W-1:0][`SIMD_EW64_W-1:0] w64;
    logic [`SIMD_DATA_W/`SIMD_EW32_W-1:0][`SIMD_EW32_W-1:0] w32;
    logic [`SIMD_DATA_W/`SIMD_EW16_W-1:0][`SIMD_EW16_W-1:0] w16;
    logic [`SIMD_DATA_W/`SIMD_EW8_W-1:0][`SIMD_EW8_W-1:0]   w8;
  } alu_lanes_t;

endpackage

// ==== verilog/simd_bitwise.sv ====
// SIMD bitwise unit
// Whole-word logic operations and lane-wise shifts of b by a

`timescale 1ns/10ps

`include "simd_alu_macros.svh"

module simd_bitwise import simd_alu_pkg::*; (
  input  alu_op_e                 op_i,
  input  vew_e                    vew_i,
  input  logic [`SIMD_DATA_W-1:0] operand_a_i,
  input  logic [`SIMD_DATA_W-1:0] operand_b_i,
  output logic [`SIMD_DATA_W-1:0] result_o
);

  // Shift result for each element width
  logic [`SIMD_NUM_EW-1:0][`SIMD_DATA_W-1:0] shift_ew;

  ////////////////////////////////////////
  // Lane shifts
  ////////////////////////////////////////

  for (genvar g = 0; g < `SIMD_NUM_EW; g++) begin : g_ew
    localparam int unsigned W     = `SIMD_EW8_W << g;
    localparam int unsigned LANES = `SIMD_DATA_W / W;
    localparam int unsigned SH    = $clog2(W);

    for (genvar l = 0; l < LANES; l++) begin : g_lane
      logic [W-1:0]  lane_b;
      logic [SH-1:0] amount;
      logic [W-1:0]  sll;
      logic [W-1:0]  srl;
      logic [W-1:0]  sra;

      assign lane_b = operand_b_i[l*W +: W];
      // Only the low bits of the a lane count
      assign amount = operand_a_i[l*W +: SH];

      assign sll = lane_b << amount;
      assign srl = lane_b >> amount;
      // Kept apart so the sign fill is not lost in a mixed expression
      assign sra = $signed(lane_b) >>> amount;

      assign shift_ew[g][l*W +: W] = (op_i == OP_SLL) ? sll :
                                     (op_i == OP_SRL) ? srl : sra;
    end
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin : p_result
    unique case (op_i)
      OP_AND:                 result_o = operand_a_i & operand_b_i;
      OP_OR:                  result_o = operand_a_i | operand_b_i;
      OP_XOR:                 result_o = operand_a_i ^ operand_b_i;
      OP_SLL, OP_SRL, OP_SRA: result_o = shift_ew[vew_i];
      default:                result_o = '0;
    endcase
  end

endmodule

// ==== verilog/simd_compare.sv ====
// SIMD compare unit
// Per-lane less and equal flags feeding min, max and element compares

`timescale 1ns/10ps

`include "simd_alu_macros.svh"

module simd_compare import simd_alu_pkg::*; (
  input  alu_op_e                 op_i,
  input  vew_e                    vew_i,
  input  logic [`SIMD_DATA_W-1:0] operand_a_i,
  input  logic [`SIMD_DATA_W-1:0] operand_b_i,
  output logic [`SIMD_DATA_W-1:0] result_o
);

  alu_lanes_t opa, opb, res;
  logic       is_signed, is_max, is_minmax, is_cmp;
  // Indexed by lane number, upper lanes idle at wider widths
  logic [7:0] less, equal, hit, pick;

  assign opa      = operand_a_i;
  assign opb      = operand_b_i;
  assign result_o = res;

  assign is_signed = op_i inside {OP_MIN, OP_MAX, OP_MSLT, OP_MSLE, OP_MSGT};
  assign is_max    = op_i inside {OP_MAX, OP_MAXU};
  assign is_minmax = op_i inside {OP_MIN, OP_MINU, OP_MAX, OP_MAXU};
  assign is_cmp    = op_i inside {OP_MSEQ, OP_MSNE, OP_MSLT, OP_MSLTU,
                                  OP_MSLE, OP_MSLEU, OP_MSGT, OP_MSGTU};

  ////////////////////////////////////////
  // Lane flags
  ////////////////////////////////////////

  // less means b below a; sign bit extended only for signed ops
  always_comb begin : p_flags
    less  = '0;
    equal = '0;
    unique case (vew_i)
      EW8: for (int l = 0; l < 8; l++) begin
        less[l]  = $signed({is_signed & opb.w8[l][7], opb.w8[l]}) <
                   $signed({is_signed & opa.w8[l][7], opa.w8[l]});
        equal[l] = opa.w8[l] == opb.w8[l];
      end
      EW16: for (int l = 0; l < 4; l++) begin
        less[l]  = $signed({is_signed & opb.w16[l][15], opb.w16[l]}) <
                   $signed({is_signed & opa.w16[l][15], opa.w16[l]});
        equal[l] = opa.w16[l] == opb.w16[l];
      end
      EW32: for (int l = 0; l < 2; l++) begin
        less[l]  = $signed({is_signed & opb.w32[l][31], opb.w32[l]}) <
                   $signed({is_signed & opa.w32[l][31], opa.w32[l]});
        equal[l] = opa.w32[l] == opb.w32[l];
      end
      default: begin
        less[0]  = $signed({is_signed & opb.w64[0][63], opb.w64[0]}) <
                   $signed({is_signed & opa.w64[0][63], opa.w64[0]});
        equal[0] = opa.w64[0] == opb.w64[0];
      end
    endcase
  end

  // Relation per compare kind
  always_comb begin : p_hit
    unique case (op_i)
      OP_MSEQ:            hit = equal;
      OP_MSNE:            hit = ~equal;
      OP_MSLT, OP_MSLTU:  hit = less;
      OP_MSLE, OP_MSLEU:  hit = less | equal;
      OP_MSGT, OP_MSGTU:  hit = ~(less | equal);
      default:            hit = '0;
    endcase
  end

  // Take b when it wins: below a for min, not below a for max
  assign pick = less ^ {8{is_max}};

  ////////////////////////////////////////
  // Result word
  ////////////////////////////////////////

  always_comb begin : p_result
    res = '0;
    if (is_cmp || is_minmax) begin
      unique case (vew_i)
        EW8: for (int l = 0; l < 8; l++)
          res.w8[l] = is_cmp ? 8'(hit[l]) : (pick[l] ? opb.w8[l] : opa.w8[l]);
        EW16: for (int l = 0; l < 4; l++)
          res.w16[l] = is_cmp ? 16'(hit[l]) : (pick[l] ? opb.w16[l] : opa.w16[l]);
        EW32: for (int l = 0; l < 2; l++)
          res.w32[l] = is_cmp ? 32'(hit[l]) : (pick[l] ? opb.w32[l] : opa.w32[l]);
        default:
          res.w64[0] = is_cmp ? 64'(hit[0]) : (pick[0] ? opb.w64[0] : opa.w64[0]);
      endcase
    end
  end

endmodule
